// ==== rtl/udp_echo_pkg.sv ====
`default_nettype none

package udp_echo_pkg;

    // Payload stream geometry
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = 8;

    // Echo service configuration
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0]  REPLY_TTL = 8'd64;

    // Payload buffer sizing
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_ADDR_WIDTH = 4;

    // Parsed request header from the UDP receive path
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        // Pads the header to 128 bits
        logic [15:0] reserved;
    } rx_udp_hdr_t;

    // Reply header towards the UDP transmit path
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } tx_udp_hdr_t;

    // One beat of UDP payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  user;
    } payload_beat_t;

    // Per-frame routing decision of the port filter
    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_ECHO,
        FILT_DROP
    } filter_state_t;

endpackage

`default_nettype wire

// ==== rtl/udp_port_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_port_filter (
    input  wire                            clk,
    input  wire                            rst,

    input  wire udp_echo_pkg::rx_udp_hdr_t rx_hdr,
    input  wire                            rx_hdr_valid,
    output logic                           rx_hdr_ready,

    input  wire udp_echo_pkg::payload_beat_t rx_payload,
    input  wire                            rx_payload_valid,
    output logic                           rx_payload_ready,

    output udp_echo_pkg::rx_udp_hdr_t      echo_hdr,
    output logic                           echo_hdr_valid,
    input  wire                            echo_hdr_ready,

    output udp_echo_pkg::payload_beat_t    echo_payload,
    output logic                           echo_payload_valid,
    input  wire                            echo_payload_ready
);

    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;

    logic port_match;
    logic hdr_xfer;
    logic last_xfer;

    assign port_match = rx_hdr.dest_port == ECHO_PORT;

    // Matching headers go straight through to the reply builder
    assign echo_hdr       = rx_hdr;
    assign echo_hdr_valid = rx_hdr_valid && port_match && (state == FILT_IDLE);

    // Other ports are swallowed without waiting on anything downstream
    always_comb begin
        if (state != FILT_IDLE) begin
            rx_hdr_ready = 1'b0;
        end else if (port_match) begin
            rx_hdr_ready = echo_hdr_ready;
        end else begin
            rx_hdr_ready = 1'b1;
        end
    end

    assign echo_payload       = rx_payload;
    assign echo_payload_valid = rx_payload_valid && (state == FILT_ECHO);

    assign rx_payload_ready = ((state == FILT_ECHO) && echo_payload_ready) ||
                              (state == FILT_DROP);

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

    always_comb begin
        state_next = state;
        unique case (state)
            FILT_IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? FILT_ECHO : FILT_DROP;
                end
            end
            FILT_ECHO, FILT_DROP: begin
                // Frame ends on the last payload beat
                if (last_xfer) begin
                    state_next = FILT_IDLE;
                end
            end
            default: begin
                state_next = FILT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Payload only reaches the FIFO while a matching frame is open
    a_echo_only_in_echo: assert property (
        @(posedge clk) disable iff (rst)
        echo_payload_valid |-> state == FILT_ECHO
    );

endmodule

`default_nettype wire

// ==== rtl/udp_reply_builder.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_reply_builder (
    input  wire                            clk,
    input  wire                            rst,

    input  wire udp_echo_pkg::rx_udp_hdr_t echo_hdr,
    input  wire                            echo_hdr_valid,
    output logic                           echo_hdr_ready,

    output udp_echo_pkg::tx_udp_hdr_t      tx_hdr,
    output logic                           tx_hdr_valid,
    input  wire                            tx_hdr_ready
);

    import udp_echo_pkg::*;

    tx_udp_hdr_t reply;
    tx_udp_hdr_t hdr_q;
    logic        valid_q;

    // Reply goes back to the sender with the ports swapped
    always_comb begin
        reply.ip_dscp      = 6'd0;
        reply.ip_ecn       = 2'd0;
        reply.ip_ttl       = REPLY_TTL;
        reply.ip_source_ip = LOCAL_IP;
        reply.ip_dest_ip   = echo_hdr.source_ip;
        reply.source_port  = echo_hdr.dest_port;
        reply.dest_port    = echo_hdr.source_port;
        reply.length       = echo_hdr.length;
        // No UDP checksum over IPv4
        reply.checksum     = 16'd0;
    end

    // Single slot, refilled in the same cycle it drains
    assign echo_hdr_ready = !valid_q || tx_hdr_ready;

    always_ff @(posedge clk) begin
        if (echo_hdr_valid && echo_hdr_ready) begin
            hdr_q <= reply;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (echo_hdr_valid && echo_hdr_ready) begin
            valid_q <= 1'b1;
        end else if (tx_hdr_ready) begin
            valid_q <= 1'b0;
        end
    end

    assign tx_hdr       = hdr_q;
    assign tx_hdr_valid = valid_q;

    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr)
    );

endmodule

`default_nettype wire

// ==== rtl/payload_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module payload_fifo (
    input  wire                              clk,
    input  wire                              rst,

    input  wire udp_echo_pkg::payload_beat_t in_beat,
    input  wire                              in_valid,
    output logic                             in_ready,

    output udp_echo_pkg::payload_beat_t      out_beat,
    output logic                             out_valid,
    input  wire                              out_ready
);

    import udp_echo_pkg::*;

    localparam logic [FIFO_ADDR_WIDTH:0] FULL_COUNT = (FIFO_ADDR_WIDTH + 1)'(FIFO_DEPTH);

    payload_beat_t mem [FIFO_DEPTH];

    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0]   count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = count != FULL_COUNT;
    assign out_valid = count != '0;
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            unique case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> count < FULL_COUNT
    );

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        rd_en |-> count != '0
    );

    // Occupancy and pointers stay consistent
    a_count_matches_ptrs: assert property (
        @(posedge clk) disable iff (rst)
        wr_ptr - rd_ptr == count[FIFO_ADDR_WIDTH-1:0]
    );

endmodule

`default_nettype wire

// ==== rtl/led_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_capture (
    input  wire                              clk,
    input  wire                              rst,
    input  wire udp_echo_pkg::payload_beat_t beat,
    input  wire                              valid,
    input  wire                              ready,
    output logic [7:0]                       led
);

    logic xfer;
    logic sof;

    assign xfer = valid && ready;

    // Start of frame is armed again by every last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            sof <= 1'b1;
        end else if (xfer) begin
            sof <= beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= 8'd0;
        end else if (xfer && sof) begin
            led <= beat.data[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/udp_echo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_echo_core (
    input  wire                              clk,
    input  wire                              rst,

    input  wire udp_echo_pkg::rx_udp_hdr_t   rx_hdr,
    input  wire                              rx_hdr_valid,
    output logic                             rx_hdr_ready,

    input  wire udp_echo_pkg::payload_beat_t rx_payload,
    input  wire                              rx_payload_valid,
    output logic                             rx_payload_ready,

    output udp_echo_pkg::tx_udp_hdr_t        tx_hdr,
    output logic                             tx_hdr_valid,
    input  wire                              tx_hdr_ready,

    output udp_echo_pkg::payload_beat_t      tx_payload,
    output logic                             tx_payload_valid,
    input  wire                              tx_payload_ready,

    output logic [7:0]                       led
);

    import udp_echo_pkg::*;

    // Filter to builder
    rx_udp_hdr_t   echo_hdr;
    logic          echo_hdr_valid;
    logic          echo_hdr_ready;

    // Filter to FIFO
    payload_beat_t echo_payload;
    logic          echo_payload_valid;
    logic          echo_payload_ready;

    udp_port_filter u_filter (
        .clk                (clk),
        .rst                (rst),
        .rx_hdr             (rx_hdr),
        .rx_hdr_valid       (rx_hdr_valid),
        .rx_hdr_ready       (rx_hdr_ready),
        .rx_payload         (rx_payload),
        .rx_payload_valid   (rx_payload_valid),
        .rx_payload_ready   (rx_payload_ready),
        .echo_hdr           (echo_hdr),
        .echo_hdr_valid     (echo_hdr_valid),
        .echo_hdr_ready     (echo_hdr_ready),
        .echo_payload       (echo_payload),
        .echo_payload_valid (echo_payload_valid),
        .echo_payload_ready (echo_payload_ready)
    );

    udp_reply_builder u_builder (
        .clk            (clk),
        .rst            (rst),
        .echo_hdr       (echo_hdr),
        .echo_hdr_valid (echo_hdr_valid),
        .echo_hdr_ready (echo_hdr_ready),
        .tx_hdr         (tx_hdr),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready)
    );

    payload_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (echo_payload),
        .in_valid  (echo_payload_valid),
        .in_ready  (echo_payload_ready),
        .out_beat  (tx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    // LED follows the outgoing payload stream
    led_capture u_led (
        .clk   (clk),
        .rst   (rst),
        .beat  (tx_payload),
        .valid (tx_payload_valid),
        .ready (tx_payload_ready),
        .led   (led)
    );

endmodule

`default_nettype wire

// ==== tests/udp_echo_tasks.svh ====
task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
endtask

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

function automatic int output_count(input int which);
    case (which)
        0: return got_hdrs.size();
        1: return got_beats.size();
        default: return got_leds.size();
    endcase
endfunction

task automatic wait_output(input int which, input string what);
    int t;
    t = 0;
    while (output_count(which) == 0) begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) begin
            fail_run($sformatf("timed out waiting for %s", what));
        end
    end
endtask

// Mode is changed away from the falling edge so the ready driver sees it cleanly
task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
    @(negedge clk);
endtask

function automatic rx_udp_hdr_t make_hdr(input logic [15:0] dest_port, input int nbeats);
    rx_udp_hdr_t h;
    h.source_ip   = $random(seed);
    h.dest_ip     = LOCAL_IP;
    h.source_port = 16'($random(seed));
    h.dest_port   = dest_port;
    h.length      = 16'(8 + 8 * nbeats);
    h.reserved    = 16'd0;
    return h;
endfunction

task automatic send_frame(input rx_udp_hdr_t hdr, input int nbeats);
    payload_beat_t beat;
    logic [31:0]   rnd;
    logic          echo;
    int            i;
    int            t;
    echo = hdr.dest_port == ECHO_PORT;
    @(negedge clk);
    rx_hdr       = hdr;
    rx_hdr_valid = 1'b1;
    t = 0;
    do begin
        @(posedge clk);
        t++;
        if (t > WAIT_LIMIT) begin
            fail_run("the request header was never accepted");
        end
    end while (!rx_hdr_ready);
    if (echo) begin
        sent_hdrs.push_back(hdr);
    end
    for (i = 0; i < nbeats; i++) begin
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        rnd          = $random(seed);
        beat.data    = {$random(seed), rnd};
        beat.keep    = (i == nbeats - 1) ? (rnd[7:0] | 8'h01) : 8'hff;
        beat.last    = i == nbeats - 1;
        beat.user    = rnd[8];
        rx_payload       = beat;
        rx_payload_valid = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                fail_run("a request payload beat was never accepted");
            end
        end while (!rx_payload_ready);
        if (echo) begin
            sent_beats.push_back(beat);
        end
    end
    @(negedge clk);
    rx_payload_valid = 1'b0;
endtask

// Takes the oldest echoed request and checks its reply, payload and LED
task automatic expect_reply();
    rx_udp_hdr_t   req;
    tx_udp_hdr_t   rep;
    payload_beat_t want;
    payload_beat_t got;
    logic [7:0]    first_byte;
    logic          first;
    logic          done;
    if (sent_hdrs.size() == 0) begin
        fail_run("no echoed request is left to compare a reply against");
    end
    req = sent_hdrs.pop_front();
    wait_output(0, "a reply header");
    rep = got_hdrs.pop_front();
    check("tx_hdr.source_port", 64'(rep.source_port), 64'(req.dest_port));
    check("tx_hdr.dest_port", 64'(rep.dest_port), 64'(req.source_port));
    check("tx_hdr.ip_dest_ip", 64'(rep.ip_dest_ip), 64'(req.source_ip));
    check("tx_hdr.ip_source_ip", 64'(rep.ip_source_ip), 64'(LOCAL_IP));
    check("tx_hdr.ip_ttl", 64'(rep.ip_ttl), 64'(REPLY_TTL));
    check("tx_hdr.ip_dscp", 64'(rep.ip_dscp), 64'd0);
    check("tx_hdr.ip_ecn", 64'(rep.ip_ecn), 64'd0);
    check("tx_hdr.checksum", 64'(rep.checksum), 64'd0);
    check("tx_hdr.length", 64'(rep.length), 64'(req.length));
    first      = 1'b1;
    done       = 1'b0;
    first_byte = 8'd0;
    while (!done) begin
        if (sent_beats.size() == 0) begin
            fail_run("the reply carried more beats than the request");
        end
        wait_output(1, "a reply payload beat");
        got  = got_beats.pop_front();
        want = sent_beats.pop_front();
        check("tx_payload.data", got.data, want.data);
        check("tx_payload.keep", 64'(got.keep), 64'(want.keep));
        check("tx_payload.last", 64'(got.last), 64'(want.last));
        check("tx_payload.user", 64'(got.user), 64'(want.user));
        if (first) begin
            first_byte = want.data[7:0];
        end
        first = 1'b0;
        done  = want.last;
    end
    wait_output(2, "the LED sample after the frame");
    check("led", 64'(got_leds.pop_front()), 64'(first_byte));
endtask

task automatic reset_state_is_idle();
    check("tx_hdr_valid", 64'(tx_hdr_valid), 64'd0);
    check("tx_payload_valid", 64'(tx_payload_valid), 64'd0);
    check("led", 64'(led), 64'd0);
    check("rx_payload_ready", 64'(rx_payload_ready), 64'd0);
endtask

task automatic echo_one_frame();
    send_frame(make_hdr(ECHO_PORT, 4), 4);
    expect_reply();
endtask

task automatic drop_other_port();
    logic [7:0] led_before;
    @(negedge clk);
    led_before = led;
    send_frame(make_hdr(16'd4321, 3), 3);
    repeat (20) @(negedge clk);
    if (got_hdrs.size() != 0 || got_beats.size() != 0) begin
        fail_run("a frame for another port produced reply traffic");
    end
    check("led", 64'(led), 64'(led_before));
    send_frame(make_hdr(ECHO_PORT, 2), 2);
    expect_reply();
endtask

// Three frames, 12 beats in all, queued behind a stalled then random ready
task automatic queue_under_backpressure();
    set_ready_mode(READY_STALL);
    send_frame(make_hdr(ECHO_PORT, 3), 3);
    repeat (10) @(negedge clk);
    // Stalled reply is offered and held
    check("tx_hdr_valid", 64'(tx_hdr_valid), 64'd1);
    check("tx_payload_valid", 64'(tx_payload_valid), 64'd1);
    set_ready_mode(READY_RANDOM);
    send_frame(make_hdr(ECHO_PORT, 4), 4);
    send_frame(make_hdr(ECHO_PORT, 5), 5);
    expect_reply();
    expect_reply();
    expect_reply();
    set_ready_mode(READY_HIGH);
endtask

// ==== tests/udp_echo_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_echo_tb;

    import udp_echo_pkg::*;

    localparam int          CLK_HALF   = 5;
    localparam logic [31:0] SEED       = 32'h91aa_8530;
    localparam int          WAIT_LIMIT = 2000;

    // Ready patterns on the reply side
    localparam int READY_HIGH   = 0;
    localparam int READY_STALL  = 1;
    localparam int READY_RANDOM = 2;

    logic          clk = 1'b0;
    logic          rst = 1'b1;

    rx_udp_hdr_t   rx_hdr = '0;
    logic          rx_hdr_valid = 1'b0;
    logic          rx_hdr_ready;
    payload_beat_t rx_payload = '0;
    logic          rx_payload_valid = 1'b0;
    logic          rx_payload_ready;
    tx_udp_hdr_t   tx_hdr;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready = 1'b1;
    payload_beat_t tx_payload;
    logic          tx_payload_valid;
    logic          tx_payload_ready = 1'b1;
    logic [7:0]    led;

    int            ready_mode = READY_HIGH;
    integer        seed;
    integer        ready_seed;
    logic [31:0]   ready_rnd;

    // Requests sent to the echo port, in order
    rx_udp_hdr_t   sent_hdrs[$];
    payload_beat_t sent_beats[$];

    // Transfers seen on the reply channels
    tx_udp_hdr_t   got_hdrs[$];
    payload_beat_t got_beats[$];
    logic [7:0]    got_leds[$];
    int            frames_out = 0;
    int            frames_led = 0;

    always #CLK_HALF clk = ~clk;

    udp_echo_core dut0 (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    // Reply-side ready, only changed on the falling edge
    always @(negedge clk) begin
        case (ready_mode)
            READY_STALL: begin
                tx_hdr_ready     = 1'b0;
                tx_payload_ready = 1'b0;
            end
            READY_RANDOM: begin
                ready_rnd        = $random(ready_seed);
                tx_hdr_ready     = ready_rnd[0];
                tx_payload_ready = ready_rnd[1];
            end
            default: begin
                tx_hdr_ready     = 1'b1;
                tx_payload_ready = 1'b1;
            end
        endcase
    end

    // Output monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                got_hdrs.push_back(tx_hdr);
            end
            if (tx_payload_valid && tx_payload_ready) begin
                got_beats.push_back(tx_payload);
                if (tx_payload.last) begin
                    frames_out = frames_out + 1;
                end
            end
        end
    end

    // LED sampled half a cycle after each frame's last beat leaves
    always @(negedge clk) begin
        if (frames_led < frames_out) begin
            got_leds.push_back(led);
            frames_led = frames_led + 1;
        end
    end

    `include "udp_echo_tasks.svh"

    initial begin
        seed       = SEED;
        ready_seed = SEED;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state_is_idle();
        echo_one_frame();
        drop_other_port();
        queue_under_backpressure();

        repeat (5) @(negedge clk);
        if (sent_hdrs.size() != 0 || got_hdrs.size() != 0 || got_beats.size() != 0) begin
            fail_run("traffic was left over after the last test");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
rtl/udp_echo_pkg.sv
rtl/udp_port_filter.sv
rtl/udp_reply_builder.sv
rtl/payload_fifo.sv
rtl/led_capture.sv
rtl/udp_echo_core.sv
tests/udp_echo_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TOP        ?= udp_echo_tb
RTL_TOP    ?= udp_echo_core
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/1ns
PASS_TEXT  ?= Result: PASSED

RTL_SRCS := $(filter rtl/%.sv,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
